// ==== logic/cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top #(
  parameter isa_pkg::word_t RESET_PC = '0   // First fetch address
) (
  input  logic           clk,
  input  logic           rst_n,
  output isa_pkg::word_t pc,                // Instruction port address
  input  isa_pkg::word_t inst,              // Answered in the same cycle
  output logic           mem_en,
  output logic           mem_wr,
  output isa_pkg::word_t mem_addr,
  output isa_pkg::word_t mem_data_out,
  input  isa_pkg::word_t mem_data_in,       // Valid in the cycle of the read
  output logic           hlt                // Sticky once HLT retires
);
  import isa_pkg::*;
  import pipe_pkg::*;

  // IF/ID and stage control
  word_t    if_id_inst;
  logic     if_id_valid;
  logic     stall;                          // Load-use hold
  logic     halt_seen;                      // HLT decoded and fetch frozen

  // ID/EX
  reg_idx_t id_rs;                          // Sources of the instruction in decode
  reg_idx_t id_rt;
  reg_idx_t ex_rs;
  reg_idx_t ex_rt;
  reg_idx_t ex_rd;
  word_t    ex_a;
  word_t    ex_b;
  word_t    ex_imm;
  alu_op_e  ex_alu_op;
  logic     ex_use_imm;
  logic     ex_mem_en;
  logic     ex_mem_wr;
  logic     ex_reg_wr;
  logic     ex_halt;
  fwd_sel_e fwd_a;
  fwd_sel_e fwd_b;

  // EX/MEM
  reg_idx_t mem_rd;
  word_t    mem_alu;                        // Result or data address
  word_t    mem_store;
  logic     mem_en_q;
  logic     mem_wr_q;
  logic     mem_reg_wr;
  logic     mem_halt;

  // MEM/WB results that loop back to decode and forwarding
  logic     wb_en;
  reg_idx_t wb_rd;
  word_t    wb_data;

  fetch_stage #(
    .RESET_PC (RESET_PC)
  ) fetch_i (
    .clk, .rst_n, .stall, .halt_seen, .inst, .pc, .if_id_inst, .if_id_valid
  );

  decode_stage decode_i (
    .clk, .rst_n, .stall, .if_id_inst, .if_id_valid, .wb_en, .wb_rd, .wb_data,
    .id_rs, .id_rt, .ex_rs, .ex_rt, .ex_rd, .ex_a, .ex_b, .ex_imm, .ex_alu_op,
    .ex_use_imm, .ex_mem_en, .ex_mem_wr, .ex_reg_wr, .ex_halt, .halt_seen
  );

  hazard_unit hazard_i (
    .id_rs, .id_rt, .ex_rd, .ex_mem_en, .ex_mem_wr, .ex_reg_wr, .if_id_valid, .stall
  );

  forwarding_unit fwd_i (
    .ex_rs, .ex_rt, .mem_rd, .wb_rd, .mem_reg_wr, .wb_en, .fwd_a, .fwd_b
  );

  execute_stage execute_i (
    .clk, .rst_n, .ex_rd, .ex_a, .ex_b, .ex_imm, .ex_alu_op, .ex_use_imm,
    .ex_mem_en, .ex_mem_wr, .ex_reg_wr, .ex_halt, .fwd_a, .fwd_b, .wb_data,
    .mem_rd, .mem_alu, .mem_store, .mem_en_q, .mem_wr_q, .mem_reg_wr, .mem_halt
  );

  memory_stage memory_i (
    .clk, .rst_n, .mem_rd, .mem_alu, .mem_store, .mem_en_q, .mem_wr_q, .mem_reg_wr,
    .mem_halt, .mem_data_in, .mem_en, .mem_wr, .mem_addr, .mem_data_out,
    .wb_en, .wb_rd, .wb_data, .hlt
  );

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              stall,          // Bubble into ID/EX
  input  isa_pkg::word_t    if_id_inst,
  input  logic              if_id_valid,
  input  logic              wb_en,          // Register file write port
  input  isa_pkg::reg_idx_t wb_rd,
  input  isa_pkg::word_t    wb_data,
  output isa_pkg::reg_idx_t id_rs,          // Zero when the field is not a source
  output isa_pkg::reg_idx_t id_rt,
  output isa_pkg::reg_idx_t ex_rs,
  output isa_pkg::reg_idx_t ex_rt,
  output isa_pkg::reg_idx_t ex_rd,
  output isa_pkg::word_t    ex_a,
  output isa_pkg::word_t    ex_b,           // rt value or rd value for SW
  output isa_pkg::word_t    ex_imm,
  output pipe_pkg::alu_op_e ex_alu_op,
  output logic              ex_use_imm,
  output logic              ex_mem_en,
  output logic              ex_mem_wr,
  output logic              ex_reg_wr,
  output logic              ex_halt,
  output logic              halt_seen
);
  import isa_pkg::*;
  import pipe_pkg::*;

  opcode_e  op;
  reg_idx_t rd;
  reg_idx_t rs;
  reg_idx_t rt;
  imm8_t    imm8;
  off4_t    off4;
  word_t    rf [NUM_REGS];                  // rf[0] unused since r0 reads as zero
  word_t    rs_val;
  word_t    rt_val;
  alu_op_e  alu_op;
  word_t    imm;
  logic     use_rs;
  logic     use_rt;
  logic     use_imm;
  logic     mem_en;
  logic     mem_wr;
  logic     reg_wr;
  logic     is_hlt;
  logic     halt_q;                         // HLT already passed decode
  logic     issue;                          // Real instruction moves to execute

  assign op   = opcode_e'(if_id_inst[OPC_LSB +: OPC_W]);
  assign rd   = if_id_inst[RD_LSB +: REG_W];
  assign rs   = if_id_inst[RS_LSB +: REG_W];
  assign rt   = if_id_inst[RT_LSB +: REG_W];
  assign imm8 = if_id_inst[IMM_W-1:0];
  assign off4 = if_id_inst[OFF_W-1:0];

  //////////////////////////////////////////////////////////////////////
  // Instruction decode
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    alu_op  = ALU_ADD;
    imm     = word_t'({off4, 1'b0});        // Word offset as byte offset
    use_rs  = 1'b0;
    use_rt  = 1'b0;
    use_imm = 1'b0;
    mem_en  = 1'b0;
    mem_wr  = 1'b0;
    reg_wr  = 1'b0;
    is_hlt  = 1'b0;
    case (op)
      OP_ADD, OP_SUB, OP_XOR: begin
        alu_op = (op == OP_SUB) ? ALU_SUB : (op == OP_XOR) ? ALU_XOR : ALU_ADD;
        use_rs = 1'b1;
        use_rt = 1'b1;
        reg_wr = 1'b1;
      end
      OP_LW: begin
        use_rs  = 1'b1;                     // Base
        use_imm = 1'b1;
        mem_en  = 1'b1;
        reg_wr  = 1'b1;
      end
      OP_SW: begin
        use_rs  = 1'b1;
        use_rt  = 1'b1;                     // Store data rides in the rt slot
        use_imm = 1'b1;
        mem_en  = 1'b1;
        mem_wr  = 1'b1;
      end
      OP_LLI: begin
        alu_op  = ALU_PASS_B;
        imm     = word_t'(imm8);            // Zero extended
        use_imm = 1'b1;
        reg_wr  = 1'b1;
      end
      OP_HLT:  is_hlt = 1'b1;
      default: ;                            // NOP
    endcase
  end

  // Unused fields read as r0, so they never hit a hazard or a forward
  assign id_rs = use_rs ? rs : '0;
  assign id_rt = !use_rt ? '0 : (op == OP_SW) ? rd : rt;

  //////////////////////////////////////////////////////////////////////
  // Register file with write-before-read bypass
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (wb_en) begin
      rf[wb_rd] <= wb_data;
    end
  end

  assign rs_val = (id_rs == '0) ? '0 : (wb_en && wb_rd == id_rs) ? wb_data : rf[id_rs];
  assign rt_val = (id_rt == '0) ? '0 : (wb_en && wb_rd == id_rt) ? wb_data : rf[id_rt];

  //////////////////////////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////////////////////////
  assign issue     = if_id_valid && !stall;
  assign halt_seen = halt_q || (if_id_valid && is_hlt);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_rs     <= '0;
      ex_rt     <= '0;
      ex_mem_en <= 1'b0;
      ex_mem_wr <= 1'b0;
      ex_reg_wr <= 1'b0;
      ex_halt   <= 1'b0;
      halt_q    <= 1'b0;
    end else begin
      ex_rs     <= issue ? id_rs : '0;      // Bubbles forward nothing
      ex_rt     <= issue ? id_rt : '0;
      ex_mem_en <= issue && mem_en;
      ex_mem_wr <= issue && mem_wr;
      ex_reg_wr <= issue && reg_wr && (rd != '0);   // r0 stays zero
      ex_halt   <= issue && is_hlt;
      halt_q    <= halt_seen;
    end
  end

  always_ff @(posedge clk) begin
    ex_rd      <= rd;
    ex_a       <= rs_val;
    ex_b       <= rt_val;
    ex_imm     <= imm;
    ex_alu_op  <= alu_op;
    ex_use_imm <= use_imm;
  end

  // Write enable is cleared for r0 here and carried down to write-back
  r0_wr_a: assert property (@(posedge clk) disable iff (!rst_n) wb_en |-> wb_rd != '0)
    else $error("write-back targets r0");

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  isa_pkg::reg_idx_t  ex_rd,
  input  isa_pkg::word_t     ex_a,
  input  isa_pkg::word_t     ex_b,
  input  isa_pkg::word_t     ex_imm,
  input  pipe_pkg::alu_op_e  ex_alu_op,
  input  logic               ex_use_imm,
  input  logic               ex_mem_en,
  input  logic               ex_mem_wr,
  input  logic               ex_reg_wr,
  input  logic               ex_halt,
  input  pipe_pkg::fwd_sel_e fwd_a,
  input  pipe_pkg::fwd_sel_e fwd_b,
  input  isa_pkg::word_t     wb_data,       // MEM/WB forward path
  output isa_pkg::reg_idx_t  mem_rd,
  output isa_pkg::word_t     mem_alu,       // Also the EX/MEM forward path
  output isa_pkg::word_t     mem_store,
  output logic               mem_en_q,
  output logic               mem_wr_q,
  output logic               mem_reg_wr,
  output logic               mem_halt
);
  import isa_pkg::*;
  import pipe_pkg::*;

  word_t op_a;
  word_t rt_val;                            // Forwarded rt and store data for SW
  word_t op_b;
  word_t alu_y;

  function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val,
                                    input word_t exmem_val, input word_t wb_val);
    case (sel)
      FWD_EXMEM: return exmem_val;
      FWD_WB:    return wb_val;
      default:   return reg_val;
    endcase
  endfunction

  assign op_a   = fwd_mux(fwd_a, ex_a, mem_alu, wb_data);
  assign rt_val = fwd_mux(fwd_b, ex_b, mem_alu, wb_data);
  assign op_b   = ex_use_imm ? ex_imm : rt_val;

  // Arithmetic wraps modulo 2^16
  always_comb begin
    case (ex_alu_op)
      ALU_SUB:    alu_y = op_a - op_b;
      ALU_XOR:    alu_y = op_a ^ op_b;
      ALU_PASS_B: alu_y = op_b;              // LLI
      default:    alu_y = op_a + op_b;       // ADD and base plus offset
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // EX/MEM register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_en_q   <= 1'b0;
      mem_wr_q   <= 1'b0;
      mem_reg_wr <= 1'b0;
      mem_halt   <= 1'b0;
    end else begin
      mem_en_q   <= ex_mem_en;
      mem_wr_q   <= ex_mem_wr;
      mem_reg_wr <= ex_reg_wr;
      mem_halt   <= ex_halt;
    end
  end

  always_ff @(posedge clk) begin
    mem_rd    <= ex_rd;
    mem_alu   <= alu_y;
    mem_store <= rt_val;
  end

  // A load in memory holds only its address so its consumer is held back a cycle
  load_fwd_a: assert property (@(posedge clk) disable iff (!rst_n)
      (mem_en_q && !mem_wr_q) |-> (fwd_a != FWD_EXMEM && fwd_b != FWD_EXMEM))
    else $error("load address forwarded as data");

endmodule

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage #(
  parameter isa_pkg::word_t RESET_PC = '0   // Must be even
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           stall,             // Load-use hold
  input  logic           halt_seen,         // HLT in or past decode
  input  isa_pkg::word_t inst,              // Instruction at pc
  output isa_pkg::word_t pc,
  output isa_pkg::word_t if_id_inst,
  output logic           if_id_valid        // Zero marks a bubble
);
  import isa_pkg::*;

  word_t pc_next;

  // PC freezes on a stall and for good after HLT
  assign pc_next = (stall || halt_seen) ? pc : pc + word_t'(INST_BYTES);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc          <= RESET_PC;
      if_id_valid <= 1'b0;                  // IF/ID starts empty
    end else begin
      pc <= pc_next;
      if (halt_seen) begin
        if_id_valid <= 1'b0;                // Nothing behind HLT is decoded
      end else if (!stall) begin
        if_id_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      if_id_inst <= inst;                   // Held while decode waits on a load
    end
  end

  // Word aligned fetch over the whole run
  pc_even_a: assert property (@(posedge clk) disable iff (!rst_n) pc[0] == 1'b0)
    else $error("pc not word aligned: %h", pc);

endmodule

// ==== logic/forwarding_unit.sv ====
`timescale 1ns/1ns

module forwarding_unit (
  input  isa_pkg::reg_idx_t  ex_rs,
  input  isa_pkg::reg_idx_t  ex_rt,
  input  isa_pkg::reg_idx_t  mem_rd,
  input  isa_pkg::reg_idx_t  wb_rd,
  input  logic               mem_reg_wr,
  input  logic               wb_en,
  output pipe_pkg::fwd_sel_e fwd_a,         // Source for operand A
  output pipe_pkg::fwd_sel_e fwd_b          // Source for rt value and store data
);
  import isa_pkg::*;
  import pipe_pkg::*;

  // Youngest producer wins so EX/MEM beats MEM/WB
  function automatic fwd_sel_e pick_src(input reg_idx_t src, input reg_idx_t mem_dst,
                                        input logic mem_wen, input reg_idx_t wb_dst,
                                        input logic wb_wen);
    if (mem_wen && mem_dst == src) begin
      return FWD_EXMEM;
    end
    if (wb_wen && wb_dst == src) begin
      return FWD_WB;
    end
    return FWD_REG;                         // Decode read is current
  endfunction

  assign fwd_a = pick_src(ex_rs, mem_rd, mem_reg_wr, wb_rd, wb_en);
  assign fwd_b = pick_src(ex_rt, mem_rd, mem_reg_wr, wb_rd, wb_en);

endmodule

// ==== logic/hazard_unit.sv ====
`timescale 1ns/1ns

module hazard_unit (
  input  isa_pkg::reg_idx_t id_rs,          // Zero when not a source
  input  isa_pkg::reg_idx_t id_rt,
  input  isa_pkg::reg_idx_t ex_rd,
  input  logic              ex_mem_en,
  input  logic              ex_mem_wr,
  input  logic              ex_reg_wr,      // Never set for r0
  input  logic              if_id_valid,
  output logic              stall           // Hold PC and IF/ID, bubble ID/EX
);

  logic ex_is_load;
  logic src_hit;

  // LW in execute has no data until memory answers
  assign ex_is_load = ex_mem_en && !ex_mem_wr && ex_reg_wr;
  assign src_hit    = (ex_rd == id_rs) || (ex_rd == id_rt);
  assign stall      = if_id_valid && ex_is_load && src_hit;

endmodule

// ==== logic/isa_pkg.sv ====
package isa_pkg;

  //////////////////////////////////////////////////////////////////////
  // Word and field widths
  //////////////////////////////////////////////////////////////////////
  localparam int WORD_W     = 16;           // Data, address and instruction
  localparam int OPC_W      = 4;
  localparam int REG_W      = 4;            // r0..r15
  localparam int NUM_REGS   = 1 << REG_W;
  localparam int IMM_W      = 8;            // LLI immediate
  localparam int OFF_W      = 4;            // Unsigned LW/SW word offset
  localparam int INST_BYTES = 2;            // PC step per instruction

  // Field positions shared by all instructions
  localparam int OPC_LSB = 12;              // inst[15:12]
  localparam int RD_LSB  = 8;               // inst[11:8]
  localparam int RS_LSB  = 4;               // inst[7:4]
  localparam int RT_LSB  = 0;               // inst[3:0]

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [REG_W-1:0]  reg_idx_t;
  typedef logic [IMM_W-1:0]  imm8_t;
  typedef logic [OFF_W-1:0]  off4_t;

  //////////////////////////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////////////////////////
  // Codes not listed here decode as NOP
  typedef enum logic [OPC_W-1:0] {
    OP_ADD = 4'd0,                          // rd = rs + rt
    OP_SUB = 4'd1,                          // rd = rs - rt
    OP_XOR = 4'd2,                          // rd = rs ^ rt
    OP_LW  = 4'd8,                          // rd = mem[rs + 2*off]
    OP_SW  = 4'd9,                          // mem[rs + 2*off] = rd
    OP_LLI = 4'd10,                         // rd = zext(inst[7:0])
    OP_HLT = 4'd15                          // Stop fetch and raise hlt at write-back
  } opcode_e;

endpackage

// ==== logic/memory_stage.sv ====
`timescale 1ns/1ns

module memory_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  isa_pkg::reg_idx_t mem_rd,
  input  isa_pkg::word_t    mem_alu,        // Result or byte address
  input  isa_pkg::word_t    mem_store,
  input  logic              mem_en_q,
  input  logic              mem_wr_q,
  input  logic              mem_reg_wr,
  input  logic              mem_halt,
  input  isa_pkg::word_t    mem_data_in,    // Same-cycle read data
  output logic              mem_en,
  output logic              mem_wr,
  output isa_pkg::word_t    mem_addr,
  output isa_pkg::word_t    mem_data_out,
  output logic              wb_en,
  output isa_pkg::reg_idx_t wb_rd,
  output isa_pkg::word_t    wb_data,
  output logic              hlt
);

  logic is_load;

  // Data port straight from EX/MEM
  assign mem_en       = mem_en_q;
  assign mem_wr       = mem_wr_q;
  assign mem_addr     = mem_alu;
  assign mem_data_out = mem_store;
  assign is_load      = mem_en_q && !mem_wr_q;

  //////////////////////////////////////////////////////////////////////
  // MEM/WB register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_en <= 1'b0;
      hlt   <= 1'b0;
    end else begin
      wb_en <= mem_reg_wr;
      hlt   <= hlt || mem_halt;             // Set as HLT enters write-back and never cleared
    end
  end

  always_ff @(posedge clk) begin
    wb_rd   <= mem_rd;
    wb_data <= is_load ? mem_data_in : mem_alu;
  end

endmodule

// ==== logic/pipe_pkg.sv ====
package pipe_pkg;

  //////////////////////////////////////////////////////////////////////
  // Pipeline control encodings
  //////////////////////////////////////////////////////////////////////

  // Operand source for the execute muxes
  typedef enum logic [1:0] {
    FWD_REG   = 2'd0,                       // Value read in decode
    FWD_EXMEM = 2'd1,                       // ALU result one stage ahead
    FWD_WB    = 2'd2                        // Write-back data two stages ahead
  } fwd_sel_e;

  // ALU function picked in decode
  typedef enum logic [1:0] {
    ALU_ADD    = 2'd0,                      // ADD and the LW/SW address
    ALU_SUB    = 2'd1,
    ALU_XOR    = 2'd2,
    ALU_PASS_B = 2'd3                       // LLI passes the immediate straight through
  } alu_op_e;

endpackage

// ==== tb.f ====
+incdir+test
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/hazard_unit.sv
logic/forwarding_unit.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/cpu_top.sv
test/tb_cpu.sv

// ==== test/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int IMEM_WORDS = 128;                // Indexed by pc[7:1]
localparam int DMEM_WORDS = 256;                // Indexed by byte address [8:1]
localparam int MAX_STORES = 128;

word_t prog [IMEM_WORDS];                       // Image of the program under test
int    prog_len;
word_t exp_addr [MAX_STORES];                   // Expected stores in program order
word_t exp_data [MAX_STORES];
int    exp_count;
word_t exp_pc;                                  // pc once HLT has been decoded
int    seed;

// Initial data word with every index bit in it
function automatic word_t fill_word(input int idx);
  return {idx[7:0], ~idx[7:0]} ^ 16'h5a3c;
endfunction

task automatic clear_program();
  for (int i = 0; i < IMEM_WORDS; i++) begin
    prog[i] = {OP_HLT, 12'h000};                // A runaway fetch halts
  end
  prog_len = 0;
endtask

task automatic add_inst(input logic [3:0] op, input reg_idx_t rd, input reg_idx_t rs,
                        input reg_idx_t rt);
  prog[prog_len] = {op, rd, rs, rt};
  prog_len++;
endtask

task automatic add_lli(input reg_idx_t rd, input imm8_t imm);
  add_inst(OP_LLI, rd, imm[7:4], imm[3:0]);
endtask

//////////////////////////////////////////////////////////////////////
// Program images
//////////////////////////////////////////////////////////////////////
task automatic build_program(input int kind);
  logic [31:0] rnd;
  logic [3:0]  alu;
  int          n;
  clear_program();
  for (int r = 1; r < 16; r++) begin
    rnd = $random(seed);
    add_lli(r[3:0], rnd[7:0]);                  // Every register defined before use
  end
  case (kind)
    0: begin                                    // Dependent ALU chain
      add_lli(1, 8'hf3);
      add_lli(2, 8'h2c);
      add_inst(OP_ADD, 3, 1, 2);                // EX/MEM and MEM/WB sources
      add_inst(OP_SUB, 4, 2, 3);                // Wraps below zero
      add_inst(OP_XOR, 5, 4, 3);
      add_inst(OP_ADD, 6, 5, 4);
      add_inst(OP_SUB, 7, 6, 6);
      add_inst(OP_XOR, 8, 8, 5);                // r8 from the prologue
    end
    1: begin                                    // Load-use
      add_lli(1, 8'h40);                        // Base
      add_inst(OP_LW,  2, 1, 3);
      add_inst(OP_ADD, 3, 2, 2);                // One stall cycle
      add_inst(OP_SW,  3, 1, 5);                // Sum as store data
      add_inst(OP_LW,  4, 1, 5);                // Word just stored
      add_inst(OP_SW,  4, 1, 6);                // Load feeds store data
      add_inst(OP_LW,  5, 1, 6);
      add_inst(OP_SUB, 6, 1, 5);
    end
    2: begin                                    // Store address pattern
      add_lli(1, 8'h10);
      add_lli(2, 8'hc8);
      add_inst(OP_SW, 1, 1, 0);
      add_inst(OP_SW, 2, 1, 7);
      add_inst(OP_SW, 1, 2, 15);
      add_inst(OP_SW, 2, 2, 1);
      add_inst(OP_SW, 0, 2, 2);                 // r0 stores zero
      add_inst(OP_SW, 1, 0, 15);
    end
    3: begin
      add_lli(9, 8'h77);
      add_inst(OP_SW, 9, 0, 4);
    end
    default: begin                              // Random body of 20 to 40 instructions
      rnd = $random(seed);
      n = 20 + rnd[15:0] % 21;
      for (int i = 0; i < n; i++) begin
        rnd = $random(seed);
        alu = rnd[13] ? OP_XOR : rnd[12] ? OP_SUB : OP_ADD;
        case (rnd[15:14])
          2'd0:    add_lli(rnd[11:8], rnd[7:0]);
          2'd1:    add_inst(alu, rnd[11:8], rnd[7:4], rnd[3:0]);
          2'd2:    add_inst(OP_LW, rnd[11:8], rnd[7:4], rnd[3:0]);
          default: add_inst(OP_SW, rnd[11:8], rnd[7:4], rnd[3:0]);
        endcase
      end
    end
  endcase
  for (int r = 1; r < 16; r++) begin
    add_inst(OP_SW, r[3:0], 0, r[3:0]);         // Register dump to 2*r
  end
  add_inst(OP_HLT, 0, 0, 0);
  if (kind == 3) begin                          // Sits behind HLT and must never run
    add_inst(OP_SW, 9, 0, 9);
    add_inst(OP_ADD, 1, 9, 9);
    add_inst(OP_SW, 1, 0, 10);
  end
endtask

//////////////////////////////////////////////////////////////////////
// ISA reference that fills the expected store list
//////////////////////////////////////////////////////////////////////
function automatic void run_reference();
  word_t      regs [16];
  word_t      mem [DMEM_WORDS];
  word_t      w;
  word_t      addr;
  logic [3:0] op;
  logic [3:0] rd;
  int         idx;
  for (int i = 0; i < DMEM_WORDS; i++) begin
    mem[i] = fill_word(i);
  end
  for (int i = 0; i < 16; i++) begin
    regs[i] = '0;
  end
  exp_count = 0;
  idx       = 0;
  op        = 4'd0;
  while (idx < prog_len && op != OP_HLT) begin
    w    = prog[idx];
    op   = w[15:12];
    rd   = w[11:8];
    addr = regs[w[7:4]] + {w[3:0], 1'b0};       // Byte address for LW and SW
    idx++;
    case (op)
      OP_ADD: regs[rd] = regs[w[7:4]] + regs[w[3:0]];
      OP_SUB: regs[rd] = regs[w[7:4]] - regs[w[3:0]];
      OP_XOR: regs[rd] = regs[w[7:4]] ^ regs[w[3:0]];
      OP_LLI: regs[rd] = {8'h00, w[7:0]};
      OP_LW:  regs[rd] = mem[addr[8:1]];
      OP_SW: begin
        mem[addr[8:1]]      = regs[rd];
        exp_addr[exp_count] = addr;
        exp_data[exp_count] = regs[rd];
        exp_count++;
      end
      default: ;                                // NOP here while HLT ends the loop
    endcase
    regs[0] = '0;                               // r0 hardwired
  end
  exp_pc = word_t'(2 * idx);                    // Fetch stops on the word after HLT
endfunction

`endif

// ==== test/tb_cpu.sv ====
`timescale 1ns/1ns

module tb_cpu;
  import isa_pkg::*;

  logic  clk;
  logic  rst_n;
  word_t pc;
  word_t inst;
  logic  mem_en;
  logic  mem_wr;
  word_t mem_addr;
  word_t mem_data_out;
  word_t mem_data_in;
  logic  hlt;

  `include "tb_model.svh"

  word_t dmem [DMEM_WORDS];                     // Data memory model
  int    error_count = 0;
  int    check_count = 0;
  int    exp_idx     = 0;                       // Next expected store
  int    prog_num    = 0;
  int    cycle_count = 0;
  int    cycle_limit = 100;                     // Raised per program

  cpu_top #(
    .RESET_PC (16'h0000)
  ) dut_i (
    .clk, .rst_n, .pc, .inst, .mem_en, .mem_wr, .mem_addr, .mem_data_out,
    .mem_data_in, .hlt
  );

  //////////////////////////////////////////////////////////////////////
  // Clock and memory models
  //////////////////////////////////////////////////////////////////////
  always #5 clk = ~clk;                         // 10 ns period

  assign inst        = prog[pc[7:1]];           // Same-cycle fetch
  assign mem_data_in = (mem_en === 1'b1 && mem_wr === 1'b0) ? dmem[mem_addr[8:1]] : '0;

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i] <= fill_word(i);                // Fresh image per program
      end
    end else if (mem_en && mem_wr) begin
      dmem[mem_addr[8:1]] <= mem_data_out;
    end
  end

  task automatic check_value(input string name, input word_t got, input word_t expected);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("ERROR %s: got %h expected %h in program %0d", name, got, expected, prog_num);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Store checker and watchdog
  //////////////////////////////////////////////////////////////////////
  always @(negedge clk) begin                   // Outputs settled mid-cycle
    if (!rst_n) begin
      exp_idx = 0;
    end else if (mem_en && mem_wr) begin
      if (exp_idx >= exp_count) begin
        error_count++;
        $display("Store to address %h not expected in program %0d", mem_addr, prog_num);
      end else begin
        check_value("mem_addr", mem_addr, exp_addr[exp_idx]);
        check_value("mem_data_out", mem_data_out, exp_data[exp_idx]);
        exp_idx++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: program %0d did not raise hlt in time", prog_num);
      $display("Programs: %0d  checks: %0d  errors: %0d", prog_num, check_count,
               error_count + 1);
      $display("Simulation failed");
      $finish;
    end
  end

  // Reset, load one program, run it to HLT and check the freeze
  task automatic run_program(input int kind);
    @(posedge clk);
    #1 rst_n = 1'b0;
    prog_num++;
    build_program(kind);
    run_reference();
    cycle_limit = cycle_count + 30 + 4 * prog_len;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    while (hlt !== 1'b1) begin
      @(posedge clk);
      #1;
    end
    check_value("pc", pc, exp_pc);
    repeat (5) begin                            // hlt stays high and pc stays frozen
      @(posedge clk);
      #1;
      check_value("hlt", hlt, 16'h0001);
      check_value("pc", pc, exp_pc);
    end
    check_value("store count", exp_idx, exp_count);
  endtask

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    seed  = 89516;
    clear_program();
    for (int k = 0; k < 4; k++) begin
      run_program(k);                           // Directed programs
    end
    repeat (10) run_program(4);                 // Random programs
    $display("Programs: %0d  checks: %0d  errors: %0d", prog_num, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
